// ==== gfx_params.svh ====
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// Configuration register file
`define GFX_RCNT        8

// Row/column scroll RAM and its CPU window
`define GFX_ZURE_N      32
`define GFX_ZURE_LO     14'h20
`define GFX_ZURE_HI     14'h60

// Graphics ROM port
`define GFX_ROM_AW      18
`define GFX_ROM_DW      16

// Blank area limits, in octal
`define GFX_VBLANK_END  9'o20
`define GFX_HWIDE_LO    9'o20
`define GFX_HWIDE_HI    9'o420
`define GFX_HNARROW_LO  9'o30
`define GFX_HNARROW_HI  9'o410

// Columns where sprites are hidden in the wide layout
`define GFX_NOOBJ_LO    9'o50
`define GFX_NOOBJ_HI    9'o360

`endif

// ==== gfx_pkg.sv ====
`include "gfx_params.svh"

package gfx_pkg;

    // CPU side strobes and write data
    typedef struct packed {
        logic        cs;
        logic        rnw;
        logic        cen;
        logic [13:0] addr;
        logic [7:0]  dout;
    } cpu_bus_t;

    // Screen position from the video timer
    typedef struct packed {
        logic       lvbl;
        logic [8:0] hdump;
        logic [8:0] vdump;
    } vid_t;

    // Control fields decoded from the register file
    typedef struct packed {
        logic [1:0] prio_en;
        logic       layout;
        logic       narrow_en;
        logic       flip;
        logic       nmi_en;
        logic       irq_en;
        logic       firq_en;
        logic       nmi_pace;
        logic [1:0] pal_bank;
    } gfx_cfg_t;

    // Renderer to arbiter
    typedef struct packed {
        logic                   cs;
        logic [`GFX_ROM_AW-1:0] addr;
    } rom_req_t;

    // Arbiter to renderer
    typedef struct packed {
        logic                   ok;
        logic [`GFX_ROM_DW-1:0] data;
    } rom_rsp_t;

endpackage

// ==== gfx_regs.sv ====
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_regs (
    input  logic              clk,
    input  logic              rst,
    input  gfx_pkg::cpu_bus_t bus,
    output logic [7:0]        dout,
    output gfx_pkg::gfx_cfg_t cfg
);

    // Memory mapped registers
    logic [7:0]             mmr [0:`GFX_RCNT-1];
    // Row/column scroll values
    logic [7:0]             zure [0:`GFX_ZURE_N-1];
    // One bit per strip, text (1) or scroll (0)
    logic [`GFX_ZURE_N-1:0] strip_map;

    logic       cpu_we;
    logic       cfg_cs;
    logic       zure_cs;
    logic [7:0] zure_cpu;

    assign cpu_we  = bus.cs & bus.cen & ~bus.rnw;
    assign cfg_cs  = bus.addr < `GFX_RCNT;
    assign zure_cs = (bus.addr >= `GFX_ZURE_LO) && (bus.addr < `GFX_ZURE_HI);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `GFX_RCNT; i++) begin
                mmr[i] <= 8'd0;
            end
            for (int i = 0; i < `GFX_ZURE_N; i++) begin
                zure[i] <= 8'd0;
            end
            strip_map <= '0;
        end else if (cpu_we) begin
            if (cfg_cs) begin
                mmr[bus.addr[2:0]] <= bus.dout;
            end
            if (zure_cs) begin
                // Upper half of the window holds the strip map
                if (bus.addr[6]) begin
                    strip_map[bus.addr[4:0]] <= bus.dout[0];
                end else begin
                    zure[bus.addr[4:0]] <= bus.dout;
                end
            end
        end
    end

    // CPU read-back
    assign zure_cpu = zure[bus.addr[4:0]];

    always_comb begin
        if (bus.addr[13]) begin
            // VRAM area, not present here
            dout = 8'd0;
        end else begin
            dout = {zure_cpu[7:1], bus.addr[6] ? strip_map[bus.addr[4:0]] : zure_cpu[0]};
        end
    end

    // Layout and priority
    assign cfg.prio_en   = {mmr[3][5], mmr[3][2]};
    assign cfg.layout    = mmr[3][4];
    assign cfg.narrow_en = mmr[3][6];

    // Palette bank
    assign cfg.pal_bank  = mmr[6][5:4];

    // Interrupt control and screen flip
    assign cfg.nmi_en    = mmr[7][0];
    assign cfg.irq_en    = mmr[7][1];
    assign cfg.firq_en   = mmr[7][2];
    assign cfg.flip      = mmr[7][3];
    assign cfg.nmi_pace  = mmr[7][4];

endmodule

// ==== gfx_irq.sv ====
`timescale 1ns/1ps

module gfx_irq (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  gfx_pkg::vid_t     vid,
    input  gfx_pkg::gfx_cfg_t cfg,
    output logic              irqn,
    output logic              nmin,
    output logic              firqn
);

    logic last_lvbl;
    logic last_irqn;
    logic last_fast;
    logic last_slow;
    logic trig_nfir;
    logic last_trig;
    logic fast_nmi;
    logic slow_nmi;
    logic nmi_edge;

    // Line counter bits for 16 and 32 line pacing
    assign fast_nmi = vid.vdump[4];
    assign slow_nmi = vid.vdump[5];
    assign nmi_edge = cfg.nmi_pace ? (slow_nmi & ~last_slow) : (fast_nmi & ~last_fast);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irqn      <= 1'b1;
            nmin      <= 1'b1;
            firqn     <= 1'b1;
            last_lvbl <= 1'b0;
            last_irqn <= 1'b1;
            last_fast <= 1'b0;
            last_slow <= 1'b0;
            trig_nfir <= 1'b1;
            last_trig <= 1'b1;
        end else if (pxl_cen) begin
            last_lvbl <= vid.lvbl;
            last_irqn <= irqn;
            last_fast <= fast_nmi;
            last_slow <= slow_nmi;
            last_trig <= trig_nfir;

            // Once per frame, at the start of vertical blank
            if (!cfg.irq_en) begin
                irqn <= 1'b1;
            end else if (!vid.lvbl && last_lvbl) begin
                irqn <= 1'b0;
            end

            if (!cfg.nmi_en) begin
                nmin <= 1'b1;
            end else if (nmi_edge) begin
                nmin <= 1'b0;
            end

            // Each IRQ release flips the phase, so FIRQ runs at half rate
            if (!last_irqn && irqn) begin
                trig_nfir <= ~trig_nfir;
            end

            if (!cfg.firq_en) begin
                firqn <= 1'b1;
            end else if (!last_trig && trig_nfir) begin
                firqn <= 1'b0;
            end
        end
    end

endmodule

// ==== gfx_rom_arb.sv ====
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_rom_arb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             gfx_en,
    input  gfx_pkg::rom_req_t      scr_req,
    input  gfx_pkg::rom_req_t      obj_req,
    output gfx_pkg::rom_rsp_t      scr_rsp,
    output gfx_pkg::rom_rsp_t      obj_rsp,
    output logic                   rom_cs,
    output logic                   rom_obj_sel,
    output logic [`GFX_ROM_AW-1:0] rom_addr,
    input  logic [`GFX_ROM_DW-1:0] rom_data,
    input  logic                   rom_ok
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SCR,
        ARB_OBJ
    } arb_state_t;

    arb_state_t             state;
    logic                   ok_wait;
    logic [1:0]             last_cs;
    logic                   scr_ok;
    logic                   obj_ok;
    logic                   done;
    logic [`GFX_ROM_DW-1:0] scr_data;
    logic [`GFX_ROM_DW-1:0] obj_data;

    // rom_ok may still be high from the previous access, hence ok_wait
    assign done = (state != ARB_IDLE) && rom_ok && ok_wait;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ARB_IDLE;
            rom_cs      <= 1'b0;
            rom_obj_sel <= 1'b0;
            rom_addr    <= '0;
            ok_wait     <= 1'b0;
            last_cs     <= 2'b00;
            scr_ok      <= 1'b0;
            obj_ok      <= 1'b0;
        end else begin
            last_cs <= {obj_req.cs, scr_req.cs};
            // A new request from a client invalidates its old answer
            if (scr_req.cs && !last_cs[0]) begin
                scr_ok <= 1'b0;
            end
            if (obj_req.cs && !last_cs[1]) begin
                obj_ok <= 1'b0;
            end
            case (state)
                ARB_IDLE: begin
                    ok_wait <= 1'b0;
                    if (scr_req.cs && gfx_en[0]) begin
                        rom_cs      <= 1'b1;
                        rom_addr    <= scr_req.addr;
                        rom_obj_sel <= 1'b0;
                        scr_ok      <= 1'b0;
                        state       <= ARB_SCR;
                    end else if (obj_req.cs && gfx_en[1]) begin
                        rom_cs      <= 1'b1;
                        rom_addr    <= obj_req.addr;
                        rom_obj_sel <= 1'b1;
                        obj_ok      <= 1'b0;
                        state       <= ARB_OBJ;
                    end else begin
                        rom_cs <= 1'b0;
                    end
                end
                default: begin
                    if (done) begin
                        if (state == ARB_SCR) begin
                            scr_ok <= 1'b1;
                        end else begin
                            obj_ok <= 1'b1;
                        end
                        rom_cs <= 1'b0;
                        state  <= ARB_IDLE;
                    end else begin
                        ok_wait <= 1'b1;
                    end
                end
            endcase
            // Disabled clients are answered at once, without an SDRAM cycle
            if (!gfx_en[0] && scr_req.cs && last_cs[0]) begin
                scr_ok <= 1'b1;
            end
            if (!gfx_en[1] && obj_req.cs && last_cs[1]) begin
                obj_ok <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!gfx_en[0]) begin
            scr_data <= '0;
        end else if (done && state == ARB_SCR) begin
            scr_data <= rom_data;
        end
        if (!gfx_en[1]) begin
            obj_data <= '0;
        end else if (done && state == ARB_OBJ) begin
            obj_data <= rom_data;
        end
    end

    assign scr_rsp.ok   = scr_ok;
    assign scr_rsp.data = scr_data;
    assign obj_rsp.ok   = obj_ok;
    assign obj_rsp.data = obj_data;

endmodule

// ==== gfx_mixer.sv ====
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_mixer (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  gfx_pkg::vid_t     vid,
    input  gfx_pkg::gfx_cfg_t cfg,
    input  logic [4:0]        tile_pxl,
    input  logic [3:0]        obj_pxl,
    output logic [6:0]        pxl_out
);

    logic       obj_blank;
    logic       tile_blank;
    logic       scrwin;
    logic       border_narrow;
    logic       border_wide;
    logic       blank_area;
    logic       no_obj;
    logic       tile_prio;
    logic       scr_sel;

    // Colour zero is transparent for both layers
    assign obj_blank  = obj_pxl == 4'h0;
    assign tile_blank = tile_pxl[3:0] == 4'h0;
    assign scrwin     = tile_pxl[4];

    // Side borders only apply to the normal layout
    assign border_narrow = cfg.narrow_en &&
        (vid.hdump < `GFX_HNARROW_LO || vid.hdump >= `GFX_HNARROW_HI);
    assign border_wide   = vid.hdump < `GFX_HWIDE_LO || vid.hdump >= `GFX_HWIDE_HI;
    assign blank_area    = vid.vdump < `GFX_VBLANK_END ||
        (!cfg.layout && (border_narrow || border_wide));

    // Text strip of the wide layout, mirrored when flipped
    assign no_obj = cfg.layout &&
        (cfg.flip ? vid.hdump >= `GFX_NOOBJ_HI : vid.hdump < `GFX_NOOBJ_LO);

    // Tiles inside the window can cover sprites
    assign tile_prio = (&cfg.prio_en) & scrwin & ~tile_blank;
    assign scr_sel   = obj_blank | no_obj | tile_prio;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_out <= '1;
        end else if (pxl_cen) begin
            if (blank_area) begin
                pxl_out <= 7'd0;
            end else if (scr_sel) begin
                pxl_out <= {cfg.pal_bank, 1'b1, tile_pxl[3:0]};
            end else begin
                pxl_out <= {cfg.pal_bank, 1'b0, obj_pxl};
            end
        end
    end

endmodule

// ==== gfx_top.sv ====
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    // CPU
    input  gfx_pkg::cpu_bus_t      bus,
    output logic [7:0]             dout,
    output logic                   irqn,
    output logic                   nmin,
    output logic                   firqn,
    // Video timing
    input  gfx_pkg::vid_t          vid,
    output logic                   flip,
    // Renderer ROM requests
    input  logic [1:0]             gfx_en,
    input  gfx_pkg::rom_req_t      scr_req,
    input  gfx_pkg::rom_req_t      obj_req,
    output gfx_pkg::rom_rsp_t      scr_rsp,
    output gfx_pkg::rom_rsp_t      obj_rsp,
    // SDRAM
    output logic                   rom_cs,
    output logic                   rom_obj_sel,
    output logic [`GFX_ROM_AW-1:0] rom_addr,
    input  logic [`GFX_ROM_DW-1:0] rom_data,
    input  logic                   rom_ok,
    // Pixels
    input  logic [4:0]             tile_pxl,
    input  logic [3:0]             obj_pxl,
    output logic [6:0]             pxl_out
);

    import gfx_pkg::*;

    gfx_cfg_t cfg;

    assign flip = cfg.flip;

    gfx_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .dout    (dout),
        .cfg     (cfg)
    );

    gfx_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vid     (vid),
        .cfg     (cfg),
        .irqn    (irqn),
        .nmin    (nmin),
        .firqn   (firqn)
    );

    gfx_rom_arb u_rom_arb (
        .clk         (clk),
        .rst         (rst),
        .gfx_en      (gfx_en),
        .scr_req     (scr_req),
        .obj_req     (obj_req),
        .scr_rsp     (scr_rsp),
        .obj_rsp     (obj_rsp),
        .rom_cs      (rom_cs),
        .rom_obj_sel (rom_obj_sel),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok)
    );

    gfx_mixer u_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .vid      (vid),
        .cfg      (cfg),
        .tile_pxl (tile_pxl),
        .obj_pxl  (obj_pxl),
        .pxl_out  (pxl_out)
    );

endmodule

// ==== tb_gfx.sv ====
`timescale 1ns/1ps
`include "gfx_params.svh"

module tb_gfx;

    import gfx_pkg::*;

    // Budget per test in clk cycles, doubled for margin
    localparam int LIMIT = 2 * (40 + 600 + 150 + 150 + 250 + 1100 + 800);

    logic clk, rst, pxl_cen;
    logic irqn, nmin, firqn, flip;
    logic rom_cs, rom_obj_sel, rom_ok;
    logic [1:0] gfx_en;
    logic [7:0] dout;
    logic [6:0] pxl_out;
    logic [4:0] tile_pxl;
    logic [3:0] obj_pxl;
    logic [`GFX_ROM_AW-1:0] rom_addr;
    logic [`GFX_ROM_DW-1:0] rom_data;
    cpu_bus_t bus;
    vid_t     vid;
    rom_req_t scr_req, obj_req;
    rom_rsp_t scr_rsp, obj_rsp;

    logic [31:0] seed = 32'hcb73_77bc;
    logic [7:0]  zm [0:31];
    logic [31:0] sm;
    logic [7:0]  r3, r6, r7;
    int cycles = 0;
    int errs = 0, test_errs = 0;
    int tests = 0, tests_bad = 0;
    logic last_rom_cs;
    logic sel_q [$];

    gfx_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Fixed content of the SDRAM model
    function automatic logic [15:0] rom_word(input logic [17:0] a);
        return a[15:0] ^ {a[17:16], 14'h2d5b};
    endfunction

    function automatic logic [7:0] ref_dout(input logic [13:0] a);
        logic [7:0] v;
        v = zm[a[4:0]];
        if (a[6]) v[0] = sm[a[4:0]];
        return a[13] ? 8'd0 : v;
    endfunction

    function automatic logic [6:0] ref_pxl(input vid_t p, input logic [4:0] t,
                                           input logic [3:0] o);
        logic blank, strip, prio;
        blank = p.vdump < `GFX_VBLANK_END;
        if (!r3[4] && (p.hdump < `GFX_HWIDE_LO || p.hdump >= `GFX_HWIDE_HI)) blank = 1'b1;
        if (!r3[4] && r3[6] &&
            (p.hdump < `GFX_HNARROW_LO || p.hdump >= `GFX_HNARROW_HI)) blank = 1'b1;
        strip = r3[4] && (r7[3] ? p.hdump >= `GFX_NOOBJ_HI : p.hdump < `GFX_NOOBJ_LO);
        prio  = r3[5] && r3[2] && t[4] && t[3:0] != 4'd0;
        if (blank) return 7'd0;
        if (o == 4'd0 || strip || prio) return {r6[5:4], 1'b1, t[3:0]};
        return {r6[5:4], 1'b0, o};
    endfunction

    task automatic report(input string name, input string exp, input string act);
        $display("Fail %s: expected %s, actual %s", name, exp, act);
        test_errs++;
    endtask

    task automatic check_byte(input string n, input logic [7:0] e, input logic [7:0] a);
        if (a !== e) report(n, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_pxl(input string n, input logic [6:0] e, input logic [6:0] a);
        if (a !== e) report(n, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_rsp(input string n, input rom_rsp_t e, input rom_rsp_t a);
        if (a !== e) report(n, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_level(input string n, input logic e, input logic a);
        if (a !== e) report(n, $sformatf("%b", e), $sformatf("%b", a));
    endtask

    task automatic finish_test(input string name);
        $display("test %-8s %s (%0d errors)", name, test_errs ? "failed" : "ok", test_errs);
        tests++;
        if (test_errs) tests_bad++;
        errs += test_errs;
        test_errs = 0;
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 32; i++) zm[i] = 8'd0;
        sm = '0;
        r3 = 8'd0;
        r6 = 8'd0;
        r7 = 8'd0;
    endtask

    task automatic cpu_write(input logic [13:0] a, input logic [7:0] d);
        @(posedge clk);
        bus <= '{cs: 1'b1, rnw: 1'b0, cen: 1'b1, addr: a, dout: d};
        @(posedge clk);
        bus <= '{cs: 1'b0, rnw: 1'b1, cen: 1'b1, addr: a, dout: 8'd0};
    endtask

    task automatic cpu_read_check(input logic [13:0] a);
        @(posedge clk);
        bus <= '{cs: 1'b1, rnw: 1'b1, cen: 1'b1, addr: a, dout: 8'd0};
        @(negedge clk);
        check_byte($sformatf("read %h", a), ref_dout(a), dout);
    endtask

    // Four pxl_cen pulses per step
    task automatic vid_step(input logic l, input logic [8:0] v);
        @(posedge clk);
        vid <= '{lvbl: l, hdump: 9'd100, vdump: v};
        repeat (8) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic arb_round(input logic [1:0] en);
        logic [17:0] sa, oa;
        rom_rsp_t rs, ro;
        logic got_s, got_o;
        int n;
        sa = rand32();
        oa = rand32();
        sel_q.delete();
        got_s = 1'b0;
        got_o = 1'b0;
        @(posedge clk);
        gfx_en  <= en;
        scr_req <= '{cs: 1'b1, addr: sa};
        obj_req <= '{cs: 1'b1, addr: oa};
        repeat (2) @(posedge clk);
        for (n = 0; n < 300 && !(got_s && got_o); n++) begin
            @(negedge clk);
            if (!got_s && scr_rsp.ok) begin
                rs = scr_rsp;
                got_s = 1'b1;
            end
            if (!got_o && obj_rsp.ok) begin
                ro = obj_rsp;
                got_o = 1'b1;
            end
            @(posedge clk);
            if (got_s) scr_req.cs <= 1'b0;
            if (got_o) obj_req.cs <= 1'b0;
        end
        if (!(got_s && got_o)) begin
            $display("Arbiter never answered both clients with gfx_en %b", en);
            test_errs++;
        end else begin
            check_rsp("scroll data",
                      rom_rsp_t'{ok: 1'b1, data: en[0] ? rom_word(sa) : 16'd0}, rs);
            check_rsp("sprite data",
                      rom_rsp_t'{ok: 1'b1, data: en[1] ? rom_word(oa) : 16'd0}, ro);
        end
        if (en == 2'b11 && sel_q.size() > 0) check_level("scroll first", 1'b0, sel_q[0]);
        foreach (sel_q[i]) begin
            check_level("no cycle for disabled client", 1'b1, en[sel_q[i]]);
        end
        // Let a repeated access drain before the next round
        do @(negedge clk); while (rom_cs);
    endtask

    always @(posedge clk) begin
        pxl_cen <= rst ? 1'b0 : ~pxl_cen;
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // SDRAM model with random latency, plus a log of each access
    int lat;
    logic pend;
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok <= 1'b0;
            pend <= 1'b0;
            last_rom_cs <= 1'b0;
        end else begin
            last_rom_cs <= rom_cs;
            if (rom_cs && !last_rom_cs) sel_q.push_back(rom_obj_sel);
            if (!rom_cs) begin
                rom_ok <= 1'b0;
                pend <= 1'b0;
            end else if (!pend && !rom_ok) begin
                pend <= 1'b1;
                lat <= 2 + rand32() % 5;
            end else if (pend) begin
                if (lat <= 1) begin
                    rom_ok <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    pend <= 1'b0;
                end else begin
                    lat <= lat - 1;
                end
            end
        end
    end

    initial begin
        logic [13:0] a;
        logic [7:0] d;
        int fc;
        rst = 1'b1;
        pxl_cen = 1'b0;
        bus = '0;
        vid = '{lvbl: 1'b1, hdump: 9'd0, vdump: 9'd0};
        gfx_en = 2'b11;
        scr_req = '0;
        obj_req = '0;
        tile_pxl = '0;
        obj_pxl = '0;
        rom_data = '0;
        rom_ok = 1'b0;
        do_reset();

        for (int i = 0; i < 64; i++) cpu_read_check(`GFX_ZURE_LO + i);
        for (int i = 0; i < 40; i++) begin
            a = `GFX_ZURE_LO + rand32() % 64;
            d = rand32();
            cpu_write(a, d);
            if (a[6]) sm[a[4:0]] = d[0];
            else zm[a[4:0]] = d;
        end
        for (int i = 0; i < 64; i++) cpu_read_check(`GFX_ZURE_LO + i);
        cpu_read_check(14'h2040);
        finish_test("scroll");

        do_reset();
        vid_step(1'b1, 9'h40);
        cpu_write(14'd7, 8'h02);
        vid_step(1'b1, 9'h40);
        check_level("irq idle", 1'b1, irqn);
        vid_step(1'b0, 9'h40);
        check_level("irq in vblank", 1'b0, irqn);
        vid_step(1'b1, 9'h40);
        check_level("irq held", 1'b0, irqn);
        cpu_write(14'd7, 8'h00);
        vid_step(1'b1, 9'h40);
        check_level("irq cleared", 1'b1, irqn);
        vid_step(1'b0, 9'h40);
        vid_step(1'b1, 9'h40);
        check_level("irq disabled", 1'b1, irqn);
        finish_test("irq");

        do_reset();
        vid_step(1'b1, 9'h00);
        cpu_write(14'd7, 8'h01);
        vid_step(1'b1, 9'h10);
        check_level("nmi every 16", 1'b0, nmin);
        cpu_write(14'd7, 8'h00);
        vid_step(1'b1, 9'h00);
        check_level("nmi cleared", 1'b1, nmin);
        cpu_write(14'd7, 8'h11);
        vid_step(1'b1, 9'h10);
        check_level("nmi skips bit 4", 1'b1, nmin);
        vid_step(1'b1, 9'h20);
        check_level("nmi every 32", 1'b0, nmin);
        finish_test("nmi");

        do_reset();
        fc = 0;
        for (int i = 0; i < 4; i++) begin
            cpu_write(14'd7, 8'h06);
            vid_step(1'b1, 9'h40);
            vid_step(1'b0, 9'h40);
            cpu_write(14'd7, 8'h04);
            vid_step(1'b1, 9'h40);
            if (!firqn) fc++;
            cpu_write(14'd7, 8'h02);
        end
        check_byte("firq count", 8'd2, fc[7:0]);
        finish_test("firq");

        do_reset();
        repeat (3) arb_round(2'b11);
        arb_round(2'b10);
        arb_round(2'b01);
        finish_test("arbiter");

        do_reset();
        for (int i = 0; i < 200; i++) begin
            if (i % 25 == 0) begin
                r3 = rand32();
                r6 = rand32();
                r7 = rand32() & 32'h08;
                cpu_write(14'd3, r3);
                cpu_write(14'd6, r6);
                cpu_write(14'd7, r7);
                @(negedge clk);
                check_level("flip", r7[3], flip);
            end
            @(posedge clk);
            vid      <= '{lvbl: 1'b1, hdump: rand32(), vdump: rand32()};
            tile_pxl <= rand32();
            obj_pxl  <= (rand32() % 3 == 0) ? 4'd0 : rand32();
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_pxl($sformatf("pixel %0d", i), ref_pxl(vid, tile_pxl, obj_pxl), pxl_out);
        end
        finish_test("mixer");

        $display("%0d tests, %0d failed, %0d errors", tests, tests_bad, errs);
        if (errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
gfx_pkg.sv
gfx_regs.sv
gfx_irq.sv
gfx_rom_arb.sv
gfx_mixer.sv
gfx_top.sv
tb_gfx.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_gfx -f files.f
	./obj_dir/Vtb_gfx | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
